// File: background/bg_line_fetch.sv
`timescale 1ns/1ps

module bg_line_fetch import ppu_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  video_timing_t        timing,
    output logic [TB_ADDR_W-1:0] tile_buffer_addr,
    input  tile_word_t           tile_buffer_data,
    output logic [TG_ADDR_W-1:0] tile_gfx_addr,
    input  gfx_word_t            tile_gfx_data,
    input  logic [5:0]           tile_index,
    output gfx_word_t            tile_gfx,
    output logic                 tile_palette
);

    // Line buffers
    gfx_word_t                 gfx_buf [TILES_PER_LINE];
    logic [TILES_PER_LINE-1:0] pal_buf;

    logic                 fetch;
    logic [5:0]           step;
    logic                 ent_vld;     // Tile buffer word on the port this cycle
    logic [5:0]           ent_idx;
    logic                 gfx_vld;     // Graphics word on the port this cycle
    logic [5:0]           gfx_idx;
    tile_entry_t          entry;
    logic [TB_ADDR_W-1:0] row_base;

    assign fetch    = timing.hsync && !timing.vblank;   // Vblank wins over hsync
    assign row_base = TB_ADDR_W'((timing.vcount / TILE_LINES) * WORDS_PER_ROW);
    assign entry    = tile_buffer_data.entry[ent_idx % TILES_PER_WORD];

    // Step counter, stops once every tile has been issued
    always_ff @(posedge clk) begin
        if (reset || !fetch) begin
            step <= '0;
        end else if (step < TILES_PER_LINE) begin
            step <= step + 6'd1;
        end
    end

    // First stage issues the tile buffer word holding tile 'step'
    always_ff @(posedge clk) begin
        if (reset || !fetch) begin
            tile_buffer_addr <= '0;
            ent_vld          <= 1'b0;
        end else if (step < TILES_PER_LINE) begin
            tile_buffer_addr <= row_base + TB_ADDR_W'(step / TILES_PER_WORD);
            ent_vld          <= 1'b1;
        end else begin
            tile_buffer_addr <= '0;
            ent_vld          <= 1'b0;
        end
    end

    // Second stage picks the entry and issues the graphics row for this line
    always_ff @(posedge clk) begin
        if (reset || !fetch) begin
            tile_gfx_addr <= '0;
            gfx_vld       <= 1'b0;
        end else if (ent_vld) begin
            tile_gfx_addr <= TG_ADDR_W'(entry.tile_id * TILE_LINES
                                        + timing.vcount % TILE_LINES);
            gfx_vld       <= 1'b1;
        end else begin
            tile_gfx_addr <= '0;
            gfx_vld       <= 1'b0;
        end
    end

    // Tile numbers ride along with each stage
    always_ff @(posedge clk) begin
        ent_idx <= step;
        gfx_idx <= ent_idx;
        if (fetch && ent_vld) begin
            pal_buf[ent_idx] <= entry.palette;
        end
        if (fetch && gfx_vld) begin
            gfx_buf[gfx_idx] <= tile_gfx_data;
        end
    end

    // Read port for the shift feed, past the line end reads as blank
    assign tile_gfx     = (tile_index < TILES_PER_LINE) ? gfx_buf[tile_index] : '0;
    assign tile_palette = (tile_index < TILES_PER_LINE) ? pal_buf[tile_index] : 1'b0;

    // Tile map is 30 rows of 10 words
    a_tb_addr_range: assert property (@(posedge clk) disable iff (reset)
        tile_buffer_addr < TB_ADDR_W'(300));

    a_gfx_idx_range: assert property (@(posedge clk) disable iff (reset)
        gfx_vld |-> gfx_idx < TILES_PER_LINE);

endmodule

// File: background/bg_shift_feed.sv
`timescale 1ns/1ps

module bg_shift_feed import ppu_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  video_timing_t timing,
    output logic [5:0]    tile_index,
    input  gfx_word_t     tile_gfx,
    input  logic          tile_palette,
    output bg_shift_t     bg_shift,
    output logic          bg_palette
);

    logic      active;
    logic      in_range;
    logic      tile_start;    // First hcount of a tile
    logic      load;
    logic      enable;
    gfx_word_t load_word;

    assign active     = !timing.vblank && !timing.hsync;
    assign tile_index = 6'(timing.hcount / HCOUNT_PER_TILE);
    assign in_range   = tile_index < TILES_PER_LINE;
    assign tile_start = (timing.hcount % HCOUNT_PER_TILE) == 0;

    always_ff @(posedge clk) begin
        if (reset) begin
            load       <= 1'b0;
            enable     <= 1'b0;
            bg_palette <= 1'b0;
        end else if (active) begin
            load       <= tile_start && in_range;
            enable     <= timing.hcount[0] == 1'b0;    // Each pixel spans two hcounts
            bg_palette <= in_range && tile_palette;
        end else begin
            // Shifter idles through blanking, palette bit holds
            load   <= 1'b0;
            enable <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (active && tile_start && in_range) begin
            load_word <= tile_gfx;
        end
    end

    assign bg_shift = '{load: load, enable: enable, load_data: load_word};

    // Tiles are 32 hcounts apart so loads never run back to back
    a_load_single: assert property (@(posedge clk) disable iff (reset)
        bg_shift.load |=> !bg_shift.load);

endmodule

// File: common/ppu_pkg.sv
package ppu_pkg;

    // Display geometry with 16x16 tiles and 2x pixel doubling
    localparam int TILES_PER_LINE     = 40;
    localparam int TILES_PER_WORD     = 4;   // Tile ids packed in one tile buffer word
    localparam int WORDS_PER_ROW      = 10;
    localparam int TILE_LINES         = 16;  // Also graphics words per tile
    localparam int HCOUNT_PER_TILE    = 32;
    localparam int PALETTE_ENTRIES    = 8;
    localparam int COLORS_PER_PALETTE = 4;

    // Memory address widths
    localparam int TB_ADDR_W  = 9;
    localparam int TG_ADDR_W  = 11;
    localparam int PAL_ADDR_W = 3;

    typedef logic [23:0] rgb_t;
    typedef logic [31:0] gfx_word_t;    // 16 pixels, 2 bits each

    typedef struct packed {
        logic       palette;
        logic [6:0] tile_id;
    } tile_entry_t;

    typedef struct packed {
        tile_entry_t [TILES_PER_WORD-1:0] entry;    // Entry 0 in the low byte
    } tile_word_t;

    typedef struct packed {
        logic [10:0] hcount;
        logic [9:0]  vcount;
        logic        vblank;
        logic        hsync;
    } video_timing_t;

    // Background shift register control
    typedef struct packed {
        logic      load;
        logic      enable;
        gfx_word_t load_data;
    } bg_shift_t;

endpackage

// File: design/palette_unit.sv
`timescale 1ns/1ps

module palette_unit import ppu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  video_timing_t         timing,
    output logic [PAL_ADDR_W-1:0] palette_addr,
    input  rgb_t                  palette_data,
    input  logic [1:0]            pixel_bits,
    input  logic                  pixel_palette,
    output rgb_t                  pixel_color
);

    rgb_t                  pal_buf [PALETTE_ENTRIES];
    logic [3:0]            load_ptr;     // Next entry to fill, 8 once the palette is in
    logic                  load_busy;
    logic [PAL_ADDR_W-1:0] pixel_idx;

    assign load_busy = load_ptr < 4'(PALETTE_ENTRIES);

    // Address follows the pointer, its low bits read 0 again once it reaches 8
    assign palette_addr = load_ptr[PAL_ADDR_W-1:0];

    // Palette bit picks the upper half of the buffer
    assign pixel_idx = PAL_ADDR_W'(pixel_bits + COLORS_PER_PALETTE * pixel_palette);

    always_ff @(posedge clk) begin
        if (reset) begin
            load_ptr <= '0;
        end else if (!timing.vblank) begin
            load_ptr <= '0;                  // Rearm for the next frame
        end else if (load_busy) begin
            load_ptr <= load_ptr + 4'd1;
        end
    end

    // Read data for palette_addr is valid in the same cycle
    always_ff @(posedge clk) begin
        if (timing.vblank && load_busy) begin
            pal_buf[load_ptr[PAL_ADDR_W-1:0]] <= palette_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pixel_color <= '0;
        end else if (!timing.vblank && !timing.hsync) begin
            pixel_color <= pal_buf[pixel_idx];
        end
    end

    // Fetch stops after the last entry and never runs past it
    a_load_ptr_range: assert property (@(posedge clk) disable iff (reset)
        load_ptr <= 4'(PALETTE_ENTRIES));

endmodule

// File: design/ppu_ctrl.sv
`timescale 1ns/1ps

module ppu_ctrl import ppu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  video_timing_t         timing,
    input  logic [1:0]            pixel_bits,
    input  logic                  pixel_palette,
    output rgb_t                  pixel_color,
    output logic [PAL_ADDR_W-1:0] palette_addr,
    input  rgb_t                  palette_data,
    output logic [TB_ADDR_W-1:0]  tile_buffer_addr,
    input  tile_word_t            tile_buffer_data,
    output logic [TG_ADDR_W-1:0]  tile_gfx_addr,
    input  gfx_word_t             tile_gfx_data,
    output bg_shift_t             bg_shift,
    output logic                  bg_palette
);

    // Line buffer read port between fetch and shift feed
    logic [5:0] tile_index;
    gfx_word_t  tile_gfx;
    logic       tile_palette;

    palette_unit palette_unit0 (
        .clk           (clk),
        .reset         (reset),
        .timing        (timing),
        .palette_addr  (palette_addr),
        .palette_data  (palette_data),
        .pixel_bits    (pixel_bits),
        .pixel_palette (pixel_palette),
        .pixel_color   (pixel_color)
    );

    bg_line_fetch bg_line_fetch0 (
        .clk              (clk),
        .reset            (reset),
        .timing           (timing),
        .tile_buffer_addr (tile_buffer_addr),
        .tile_buffer_data (tile_buffer_data),
        .tile_gfx_addr    (tile_gfx_addr),
        .tile_gfx_data    (tile_gfx_data),
        .tile_index       (tile_index),
        .tile_gfx         (tile_gfx),
        .tile_palette     (tile_palette)
    );

    bg_shift_feed bg_shift_feed0 (
        .clk          (clk),
        .reset        (reset),
        .timing       (timing),
        .tile_index   (tile_index),
        .tile_gfx     (tile_gfx),
        .tile_palette (tile_palette),
        .bg_shift     (bg_shift),
        .bg_palette   (bg_palette)
    );

endmodule

// File: ppu_ctrl.f
common/ppu_pkg.sv
background/bg_line_fetch.sv
background/bg_shift_feed.sv
design/palette_unit.sv
design/ppu_ctrl.sv
tb/ppu_mem_model.sv
tb/tb_ppu_ctrl.sv

// File: tb/ppu_mem_model.sv
`timescale 1ns/1ps

module ppu_mem_model import ppu_pkg::*; (
    input  logic [TB_ADDR_W-1:0]  tile_buffer_addr,
    output tile_word_t            tile_buffer_data,
    input  logic [TG_ADDR_W-1:0]  tile_gfx_addr,
    output gfx_word_t             tile_gfx_data,
    input  logic [PAL_ADDR_W-1:0] palette_addr,
    output rgb_t                  palette_data
);

    logic [31:0] tile_mem [2**TB_ADDR_W];   // Four tile entries per word
    logic [31:0] gfx_mem  [2**TG_ADDR_W];
    logic [23:0] pal_mem  [2**PAL_ADDR_W];
    integer      seed;

    initial begin
        seed = 40;
        for (int i = 0; i < 2**TB_ADDR_W; i++) begin
            tile_mem[i] = $random(seed);
        end
        for (int i = 0; i < 2**TG_ADDR_W; i++) begin
            gfx_mem[i] = $random(seed);
        end
        for (int i = 0; i < 2**PAL_ADDR_W; i++) begin
            pal_mem[i] = 24'($random(seed));
        end
    end

    // Reads are combinational, the DUT captures data at the next edge
    assign tile_buffer_data = tile_word_t'(tile_mem[tile_buffer_addr]);
    assign tile_gfx_data    = gfx_mem[tile_gfx_addr];
    assign palette_data     = pal_mem[palette_addr];

endmodule

// File: tb/tb_ppu_ctrl.sv
`timescale 1ns/1ps

module tb_ppu_ctrl import ppu_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int SWEEP_LEN  = 1301;      // hcount 0 to 1300
    localparam int RUN_CYCLES = 3 + 12 + 2 * (50 + SWEEP_LEN) + 2;
    localparam int TIMEOUT_NS = RUN_CYCLES * CLK_PERIOD * 3 / 2;

    logic                  clk;
    logic                  reset;
    video_timing_t         timing;
    logic [1:0]            pixel_bits;
    logic                  pixel_palette;
    rgb_t                  pixel_color;
    logic [PAL_ADDR_W-1:0] palette_addr;
    rgb_t                  palette_data;
    logic [TB_ADDR_W-1:0]  tile_buffer_addr;
    tile_word_t            tile_buffer_data;
    logic [TG_ADDR_W-1:0]  tile_gfx_addr;
    gfx_word_t             tile_gfx_data;
    bg_shift_t             bg_shift;
    logic                  bg_palette;

    integer    seed;
    int        error_count = 0;
    logic      palette_ready = 1'b0;
    logic      after_reset = 1'b0;
    logic      exp_load;
    logic      exp_enable;
    logic      exp_bg_palette;
    logic      color_chk;
    rgb_t      exp_color;
    gfx_word_t exp_load_data;
    logic      tb_active;
    logic      tb_start;
    logic      tb_in_range;
    logic [5:0]  tb_tile;
    logic [49:0] reset_view;

    ppu_ctrl dut0 (
        .clk              (clk),
        .reset            (reset),
        .timing           (timing),
        .pixel_bits       (pixel_bits),
        .pixel_palette    (pixel_palette),
        .pixel_color      (pixel_color),
        .palette_addr     (palette_addr),
        .palette_data     (palette_data),
        .tile_buffer_addr (tile_buffer_addr),
        .tile_buffer_data (tile_buffer_data),
        .tile_gfx_addr    (tile_gfx_addr),
        .tile_gfx_data    (tile_gfx_data),
        .bg_shift         (bg_shift),
        .bg_palette       (bg_palette)
    );

    ppu_mem_model mem0 (
        .tile_buffer_addr (tile_buffer_addr),
        .tile_buffer_data (tile_buffer_data),
        .tile_gfx_addr    (tile_gfx_addr),
        .tile_gfx_data    (tile_gfx_data),
        .palette_addr     (palette_addr),
        .palette_data     (palette_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Tile k of the line at vcount, taken straight from the tile map
    function automatic logic [7:0] tile_entry_at(input logic [9:0] vcount, input int k);
        logic [31:0] word;
        word = mem0.tile_mem[(vcount / 16) * 10 + k / 4];
        return word[8 * (k % 4) +: 8];
    endfunction

    function automatic logic [31:0] expected_gfx(input logic [9:0] vcount, input int k);
        logic [7:0] entry;
        entry = tile_entry_at(vcount, k);
        return mem0.gfx_mem[entry[6:0] * 16 + vcount % 16];
    endfunction

    function automatic logic expected_palette(input logic [9:0] vcount, input int k);
        logic [7:0] entry;
        entry = tile_entry_at(vcount, k);
        return entry[7];
    endfunction

    task automatic stop_with_error(input string what);
        error_count++;
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped at the first failed check");
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic run_line(input logic [9:0] vcount);
        timing.vblank = 1'b0;
        timing.hsync  = 1'b1;
        timing.vcount = vcount;
        timing.hcount = '0;
        repeat (50) next_cycle();                 // Fetch needs 42 of these
        timing.hsync = 1'b0;
        for (int h = 0; h < SWEEP_LEN; h++) begin
            timing.hcount = 11'(h);
            pixel_bits    = 2'($random(seed));
            pixel_palette = 1'($random(seed));
            next_cycle();
        end
    endtask

    assign tb_active   = !timing.vblank && !timing.hsync;
    assign tb_tile     = timing.hcount[10:5];
    assign tb_in_range = tb_tile < TILES_PER_LINE;
    assign tb_start    = timing.hcount[4:0] == 5'd0;
    assign reset_view  = {bg_shift.load, bg_shift.enable, bg_palette, pixel_color,
                          palette_addr, tile_buffer_addr, tile_gfx_addr};

    // Reference values, each one due on the DUT outputs one cycle later
    always @(posedge clk) begin
        after_reset <= reset;
        if (reset) begin
            exp_load       <= 1'b0;
            exp_enable     <= 1'b0;
            exp_bg_palette <= 1'b0;
            color_chk      <= 1'b0;
        end else begin
            exp_load   <= tb_active && tb_start && tb_in_range;
            exp_enable <= tb_active && !timing.hcount[0];
            color_chk  <= tb_active && palette_ready;
            exp_color  <= mem0.pal_mem[pixel_bits + 4 * pixel_palette];
            if (tb_active && tb_start && tb_in_range) begin
                exp_load_data <= expected_gfx(timing.vcount, tb_tile);
            end
            if (tb_active) begin
                exp_bg_palette <= tb_in_range && expected_palette(timing.vcount, tb_tile);
            end
        end
    end

    a_reset_zero: assert property (@(posedge clk) after_reset |-> reset_view == '0)
        else stop_with_error($sformatf("mismatch reset expected 0 actual %h",
                                       $sampled(reset_view)));

    a_colour: assert property (@(posedge clk) disable iff (reset)
        color_chk |-> pixel_color == exp_color)
        else stop_with_error($sformatf("mismatch colour_lookup expected %h actual %h",
                                       $sampled(exp_color), $sampled(pixel_color)));

    a_load_word: assert property (@(posedge clk) disable iff (reset)
        bg_shift.load |-> bg_shift.load_data == exp_load_data)
        else stop_with_error($sformatf("mismatch load_word expected %h actual %h",
                                       $sampled(exp_load_data),
                                       $sampled(bg_shift.load_data)));

    a_load_position: assert property (@(posedge clk) disable iff (reset)
        bg_shift.load == exp_load)
        else stop_with_error($sformatf("mismatch load_position expected %b actual %b",
                                       $sampled(exp_load), $sampled(bg_shift.load)));

    a_enable: assert property (@(posedge clk) disable iff (reset)
        bg_shift.enable == exp_enable)
        else stop_with_error($sformatf("mismatch enable expected %b actual %b",
                                       $sampled(exp_enable), $sampled(bg_shift.enable)));

    a_bg_palette: assert property (@(posedge clk) disable iff (reset)
        bg_palette == exp_bg_palette)
        else stop_with_error($sformatf("mismatch bg_palette expected %b actual %b",
                                       $sampled(exp_bg_palette), $sampled(bg_palette)));

    initial begin
        #(TIMEOUT_NS);
        stop_with_error("Watchdog expired before the stimulus finished");
    end

    initial begin
        seed          = 40;
        reset         = 1'b1;
        timing        = '{hcount: '0, vcount: '0, vblank: 1'b1, hsync: 1'b0};
        pixel_bits    = '0;
        pixel_palette = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (12) next_cycle();                 // Palette loads in vblank
        palette_ready = 1'b1;
        run_line(10'd37);
        run_line(10'd218);
        timing.vblank = 1'b1;
        repeat (2) next_cycle();
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
